// ==== common/inst_buf_pkg.sv ====
package inst_buf_pkg;

	// Instruction word width matches the APB data width
	localparam int INST_W = 32;

	typedef struct packed {
		logic [7:0]        opcode;
		logic [INST_W-9:0] operand;
	} inst_t;

	//////////////////////////////////////////////////////////////////////
	// APB
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [7:0]        paddr;
		logic [INST_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [INST_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// One-cycle strobes from the register block
	typedef struct packed {
		logic load;
		logic start;
		logic clear;
	} buf_cmd_t;

	// Register map
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_STATUS = 8'h04;
	localparam logic [7:0] REG_INST   = 8'h08;

	// Bits of REG_CTRL
	localparam int CTRL_START = 0;
	localparam int CTRL_CLEAR = 1;

endpackage

// ==== source/apb_loader.sv ====
`timescale 1ns/10ps

module apb_loader #(
	parameter int IM_ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  inst_buf_pkg::apb_req_t apb_req,
	output inst_buf_pkg::apb_rsp_t apb_rsp,
	input  logic                   busy,
	input  logic                   done,
	input  logic [IM_ADDR_W:0]     count,
	input  logic                   full,
	output inst_buf_pkg::buf_cmd_t cmd,
	output inst_buf_pkg::inst_t    wr_data
);

	logic                            setup_q;
	logic                            access;
	logic                            wr_acc;
	logic                            rd_acc;
	logic                            hit_ctrl;
	logic                            hit_status;
	logic                            hit_inst;
	logic                            start_req;
	logic                            clear_req;
	logic                            load_err;
	logic                            start_err;
	logic                            clear_err;
	logic                            addr_err;
	logic [inst_buf_pkg::INST_W-1:0] status_word;

	// Setup phase seen on the previous cycle, so each transfer strobes once
	always_ff @(posedge clk) begin
		if (rst) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= apb_req.psel && !apb_req.penable;
		end
	end

	assign access = apb_req.psel && apb_req.penable && setup_q;
	assign wr_acc = access && apb_req.pwrite;
	assign rd_acc = access && !apb_req.pwrite;

	assign hit_ctrl   = apb_req.paddr == inst_buf_pkg::REG_CTRL;
	assign hit_status = apb_req.paddr == inst_buf_pkg::REG_STATUS;
	assign hit_inst   = apb_req.paddr == inst_buf_pkg::REG_INST;

	assign start_req = wr_acc && hit_ctrl && apb_req.pwdata[inst_buf_pkg::CTRL_START];
	assign clear_req = wr_acc && hit_ctrl && apb_req.pwdata[inst_buf_pkg::CTRL_CLEAR];

	//////////////////////////////////////////////////////////////////////
	// Refusal rules
	//////////////////////////////////////////////////////////////////////

	assign load_err = wr_acc && hit_inst && (busy || full);
	// Start and clear in one write are refused together
	assign start_err = start_req && (busy || count == '0 || clear_req);
	assign clear_err = clear_req && (busy || start_req);
	// Status is read only
	assign addr_err = wr_acc && !hit_ctrl && !hit_inst;

	assign cmd.load  = wr_acc && hit_inst && !load_err;
	assign cmd.start = start_req && !start_err;
	assign cmd.clear = clear_req && !clear_err;

	assign wr_data = inst_buf_pkg::inst_t'(apb_req.pwdata);

	always_comb begin
		status_word       = '0;
		status_word[0]    = busy;
		status_word[1]    = done;
		status_word[15:8] = 8'(count);
	end

	// Unknown offsets and the control register read as zero
	assign apb_rsp.prdata  = (rd_acc && hit_status) ? status_word : '0;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = load_err || start_err || clear_err || addr_err;

endmodule

// ==== inst_buf/inst_counters.sv ====
`timescale 1ns/10ps

module inst_counters #(
	parameter int IM_ADDR_W = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load,
	input  logic                 clear,
	input  logic                 start,
	input  logic                 pc_step,
	output logic [IM_ADDR_W-1:0] wr_addr,
	output logic [IM_ADDR_W-1:0] rd_addr,
	output logic [IM_ADDR_W:0]   count,
	output logic                 full,
	output logic                 last
);

	localparam int DEPTH = 2 ** IM_ADDR_W;

	logic [IM_ADDR_W:0]   load_ptr;
	logic [IM_ADDR_W-1:0] pc;

	// Load pointer with one extra bit so a full buffer is distinct from empty
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			load_ptr <= '0;
		end else if (load && !full) begin
			load_ptr <= load_ptr + 1'b1;
		end
	end

	// Replay program counter
	always_ff @(posedge clk) begin
		if (rst || start) begin
			pc <= '0;
		end else if (pc_step) begin
			pc <= pc + 1'b1;
		end
	end

	assign wr_addr = load_ptr[IM_ADDR_W-1:0];
	assign rd_addr = pc;
	assign count   = load_ptr;
	assign full    = load_ptr == (IM_ADDR_W+1)'(DEPTH);
	assign last    = {1'b0, pc} == load_ptr - 1'b1;

endmodule

// ==== inst_buf/replay_fsm.sv ====
`timescale 1ns/10ps

module replay_fsm (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic clear,
	input  logic last,
	input  logic slot_free,
	output logic rd_en,
	output logic pc_step,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} state_t;

	state_t state;
	state_t state_next;
	logic   done_set;

	always_comb begin
		state_next = state;
		rd_en      = 1'b0;
		done_set   = 1'b0;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = RUN;
				end
			end
			RUN: begin
				// One read per cycle while the output slot can take it
				rd_en = slot_free;
				if (slot_free && last) begin
					state_next = DRAIN;
				end
			end
			DRAIN: begin
				// Wait for the final word to leave the slot
				if (slot_free) begin
					state_next = IDLE;
					done_set   = 1'b1;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Done holds until the next start or clear
	always_ff @(posedge clk) begin
		if (rst || start || clear) begin
			done <= 1'b0;
		end else if (done_set) begin
			done <= 1'b1;
		end
	end

	assign pc_step = rd_en;
	assign busy    = state != IDLE;

endmodule

// ==== inst_buf/inst_mem.sv ====
`timescale 1ns/10ps

module inst_mem #(
	parameter int IM_ADDR_W = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr_en,
	input  logic [IM_ADDR_W-1:0] wr_addr,
	input  inst_buf_pkg::inst_t  wr_data,
	input  logic                 rd_en,
	input  logic [IM_ADDR_W-1:0] rd_addr,
	output inst_buf_pkg::inst_t  inst,
	output logic                 inst_valid,
	input  logic                 inst_ready,
	output logic                 slot_free
);

	localparam int DEPTH = 2 ** IM_ADDR_W;

	inst_buf_pkg::inst_t mem [DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read lands directly in the output slot
	always_ff @(posedge clk) begin
		if (rd_en) begin
			inst <= mem[rd_addr];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output slot
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (rd_en) begin
			inst_valid <= 1'b1;
		end else if (inst_ready) begin
			// Accepted with nothing behind it
			inst_valid <= 1'b0;
		end
	end

	// Empty, or emptied by a transfer on this edge
	assign slot_free = !inst_valid || inst_ready;

endmodule

// ==== source/inst_buf_top.sv ====
`timescale 1ns/10ps

module inst_buf_top #(
	parameter int IM_ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  inst_buf_pkg::apb_req_t apb_req,
	output inst_buf_pkg::apb_rsp_t apb_rsp,
	output inst_buf_pkg::inst_t    inst,
	output logic                   inst_valid,
	input  logic                   inst_ready
);

	inst_buf_pkg::buf_cmd_t cmd;
	inst_buf_pkg::inst_t    wr_data;
	logic                   busy;
	logic                   done;
	logic [IM_ADDR_W:0]     count;
	logic                   full;
	logic                   last;
	logic [IM_ADDR_W-1:0]   wr_addr;
	logic [IM_ADDR_W-1:0]   rd_addr;
	logic                   rd_en;
	logic                   pc_step;
	logic                   slot_free;

	// Register block
	apb_loader #(.IM_ADDR_W(IM_ADDR_W)) apb_loader_inst (
		.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.busy(busy), .done(done), .count(count), .full(full),
		.cmd(cmd), .wr_data(wr_data)
	);

	// Load pointer and program counter
	inst_counters #(.IM_ADDR_W(IM_ADDR_W)) inst_counters_inst (
		.clk(clk), .rst(rst), .load(cmd.load), .clear(cmd.clear),
		.start(cmd.start), .pc_step(pc_step), .wr_addr(wr_addr),
		.rd_addr(rd_addr), .count(count), .full(full), .last(last)
	);

	replay_fsm replay_fsm_inst (
		.clk(clk), .rst(rst), .start(cmd.start), .clear(cmd.clear),
		.last(last), .slot_free(slot_free), .rd_en(rd_en),
		.pc_step(pc_step), .busy(busy), .done(done)
	);

	// Program memory and stream output
	inst_mem #(.IM_ADDR_W(IM_ADDR_W)) inst_mem_inst (
		.clk(clk), .rst(rst), .wr_en(cmd.load), .wr_addr(wr_addr),
		.wr_data(wr_data), .rd_en(rd_en), .rd_addr(rd_addr),
		.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.slot_free(slot_free)
	);

endmodule

// ==== sim/tb_inst_buf.sv ====
`timescale 1ns/10ps

module tb_inst_buf;

	localparam int IM_ADDR_W = 4;
	localparam int DEPTH = 2 ** IM_ADDR_W;
	localparam int TIMEOUT = 100;

	logic                   clk = 1'b0;
	logic                   rst;
	inst_buf_pkg::apb_req_t apb_req;
	inst_buf_pkg::apb_rsp_t apb_rsp;
	inst_buf_pkg::inst_t    inst;
	logic                   inst_valid;
	logic                   inst_ready = 1'b0;

	integer              seed;
	logic                rand_ready;
	logic                ready_level;
	logic [31:0]         ready_rnd;
	int                  errors;
	int                  mark;
	int                  tests;
	int                  failed;
	int                  delivered;
	int                  n;
	inst_buf_pkg::inst_t prog[$];
	inst_buf_pkg::inst_t pending[$];

	inst_buf_top #(.IM_ADDR_W(IM_ADDR_W)) inst_buf_top_inst (
		.clk(clk), .rst(rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready)
	);

	always #2 clk = ~clk;

	// Consumer ready as a fixed level or random per cycle
	always @(posedge clk) begin
		#1;
		ready_rnd = $random(seed);
		inst_ready = rand_ready ? ready_rnd[0] : ready_level;
	end

	//////////////////////////////////////////////////////////////////////
	// Stream checks
	//////////////////////////////////////////////////////////////////////

	// Every accepted word must be the oldest one still expected
	always @(posedge clk) begin
		if (!rst && inst_valid && inst_ready) begin
			assert (pending.size() != 0) else begin
				errors++;
				$display("Extra instruction %h delivered at %0t", inst, $time);
			end
			if (pending.size() != 0) begin
				assert (inst == pending[0]) else begin
					errors++;
					$display("Mismatch at %0t: inst %h, expected %h", $time, inst, pending[0]);
				end
				pending.delete(0);
				delivered++;
			end
		end
	end

	stall_hold: assert property (@(posedge clk) disable iff (rst)
		inst_valid && !inst_ready |=> inst_valid && $stable(inst))
		else begin
			errors++;
			$display("Mismatch at %0t: stream changed while stalled", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// APB and helpers
	//////////////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
			input logic exp_err, output logic [31:0] rd);
		@(posedge clk);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		// Sampled 1 ns before the edge that ends the access
		#2;
		rd = apb_rsp.prdata;
		assert (apb_rsp.pready) else begin
			errors++;
			$display("Mismatch at %0t: pready low at offset %h", $time, addr);
		end
		assert (apb_rsp.pslverr == exp_err) else begin
			errors++;
			$display("Mismatch at %0t: pslverr %b at offset %h, expected %b",
				$time, apb_rsp.pslverr, addr, exp_err);
		end
		@(posedge clk);
		#1;
		apb_req = '0;
		if (wr && !exp_err) begin
			if (addr == inst_buf_pkg::REG_INST) begin
				prog.push_back(inst_buf_pkg::inst_t'(data));
			end else if (data[inst_buf_pkg::CTRL_START]) begin
				pending = prog;
			end else if (data[inst_buf_pkg::CTRL_CLEAR]) begin
				prog.delete();
			end
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused_rd;
		apb_xfer(1'b1, addr, data, exp_err, unused_rd);
	endtask

	task automatic check_status(input logic busy, input logic done, input int count);
		logic [31:0] word;
		apb_xfer(1'b0, inst_buf_pkg::REG_STATUS, '0, 1'b0, word);
		assert (word[0] == busy && word[1] == done && word[15:8] == 8'(count)) else begin
			errors++;
			$display("Mismatch at %0t: status %h, expected busy %b done %b count %0d",
				$time, word, busy, done, count);
		end
	endtask

	task automatic load_words(input int count, input logic [31:0] base);
		for (int i = 0; i < count; i++) begin
			apb_write(inst_buf_pkg::REG_INST, base + 32'(i) * 32'h0101_0011, 1'b0);
		end
	endtask

	task automatic give_up(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("Simulation failed");
		$finish;
	endtask

	// Poll status until the replay is over, then compare the delivered total
	task automatic finish_replay(input int exp_n);
		logic [31:0] word;
		int polls;
		polls = 0;
		word = 32'h1;
		while (word[0] && polls < TIMEOUT) begin
			apb_xfer(1'b0, inst_buf_pkg::REG_STATUS, '0, 1'b0, word);
			polls++;
		end
		if (word[0]) begin
			give_up("the end of replay");
		end else begin
			assert (word[1] && delivered == exp_n && pending.size() == 0) else begin
				errors++;
				$display("Mismatch at %0t: done %b, %0d delivered, expected %0d",
					$time, word[1], delivered, exp_n);
			end
		end
	endtask

	task automatic open_test();
		mark = errors;
		delivered = 0;
	endtask

	task automatic close_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("Test %0d %s: FAILED with %0d errors", tests, name, errors - mark);
		end
	endtask

	initial begin
		rst = 1'b1;
		apb_req = '0;
		seed = 98;
		rand_ready = 1'b0;
		ready_level = 1'b1;
		errors = 0;
		tests = 0;
		failed = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		open_test();
		assert (!inst_valid) else begin
			errors++;
			$display("Mismatch at %0t: inst_valid high after reset", $time);
		end
		check_status(1'b0, 1'b0, 0);
		close_test("reset state");

		open_test();
		load_words(5, 32'h1000_0000);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b0);
		// Edges counted from the start of the access phase
		n = 1;
		while (!inst_valid && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!inst_valid) begin
			give_up("the first instruction");
		end else begin
			assert (n == 2) else begin
				errors++;
				$display("Mismatch at %0t: first word after %0d cycles, expected 2", $time, n);
			end
		end
		n = 0;
		while (inst_valid && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (inst_valid) begin
			give_up("the end of the stream");
		end else begin
			assert (n == 5) else begin
				errors++;
				$display("Mismatch at %0t: valid for %0d cycles, expected 5", $time, n);
			end
		end
		finish_replay(5);
		check_status(1'b0, 1'b1, 5);
		close_test("replay with ready high");

		open_test();
		rand_ready = 1'b1;
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b0);
		finish_replay(5);
		close_test("replay with random ready");

		open_test();
		rand_ready = 1'b0;
		ready_level = 1'b0;
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b0);
		apb_write(inst_buf_pkg::REG_INST, 32'hdead_0001, 1'b1);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b1);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h2, 1'b1);
		check_status(1'b1, 1'b0, 5);
		ready_level = 1'b1;
		finish_replay(5);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h2, 1'b0);
		check_status(1'b0, 1'b0, 0);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b1);
		repeat (4) begin
			@(posedge clk);
			#1;
			assert (!inst_valid) else begin
				errors++;
				$display("Mismatch at %0t: inst_valid high after refused start", $time);
			end
		end
		close_test("refused commands");

		open_test();
		load_words(DEPTH, 32'h5000_0000);
		apb_write(inst_buf_pkg::REG_INST, 32'hffff_ffff, 1'b1);
		check_status(1'b0, 1'b0, DEPTH);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b0);
		finish_replay(DEPTH);
		close_test("full buffer");

		open_test();
		apb_write(inst_buf_pkg::REG_CTRL, 32'h2, 1'b0);
		load_words(3, 32'h6000_0000);
		apb_write(inst_buf_pkg::REG_CTRL, 32'h1, 1'b0);
		finish_replay(3);
		check_status(1'b0, 1'b1, 3);
		close_test("clear and reload");

		$display("Tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
common/inst_buf_pkg.sv
source/apb_loader.sv
inst_buf/inst_counters.sv
inst_buf/replay_fsm.sv
inst_buf/inst_mem.sv
source/inst_buf_top.sv
sim/tb_inst_buf.sv

// ==== Makefile ====
# Verilator build and regression for the instruction buffer

VERILATOR ?= verilator
TOP       ?= tb_inst_buf
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
